//--- design/exu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module exu (
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    input  logic             reg_write_en,
    input  logic [4:0]       rd_addr,
    input  logic [`XLEN-1:0] pc,
    input  rv_pkg::opcode_e  opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  logic [`XLEN-1:0] mem_data,
    input  logic             inst_invalid,
    output logic [`XLEN-1:0] result,
    output logic [4:0]       rd_addr_out,
    output logic             reg_write_en_out,
    output logic [`XLEN-1:0] next_pc
);
    import rv_pkg::*;

    logic [`XLEN-1:0]        alu_a;
    logic [`XLEN-1:0]        alu_b;
    logic [4:0]              shamt;
    logic [`XLEN-1:0]        alu_out;
    logic [`XLEN-1:0]        load_data;
    logic [`XLEN-1:0]        selected;
    logic signed [2*`XLEN-1:0] mul_full;
    logic                    div_ovf;
    logic [`XLEN-1:0]        pc_plus4;
    logic [`XLEN-1:0]        pc_imm;
    logic [`XLEN-1:0]        jalr_target;
    logic                    branch_taken;

    mux_key_default #(3, 7, `XLEN) alu_a_select (
        .out        (alu_a),
        .key        (opcode),
        .default_out(rs1_data),
        .lut        ({OP_AUIPC, pc, OP_LUI, {`XLEN{1'b0}}, OP_JAL, pc})
    );

    mux_key_default #(2, 7, `XLEN) alu_b_select (
        .out        (alu_b),
        .key        (opcode),
        .default_out(imm),
        .lut        ({OP_OP, rs2_data, OP_BRANCH, rs2_data})
    );

    assign shamt    = alu_b[4:0]; // imm for OP-IMM, rs2 for OP
    assign mul_full = $signed(alu_a) * $signed(alu_b);
    assign div_ovf  = (alu_a == 32'h8000_0000) && (alu_b == 32'hFFFF_FFFF);

    always_comb begin
        if (inst_invalid) begin
            alu_out = '0;
        end else begin
            casez ({opcode, funct3, funct7})
                {OP_OP_IMM, 3'b000, 7'b???????}: alu_out = alu_a + alu_b;
                {OP_OP_IMM, 3'b010, 7'b???????}: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
                {OP_OP_IMM, 3'b011, 7'b???????}: alu_out = {31'b0, alu_a < alu_b};
                {OP_OP_IMM, 3'b100, 7'b???????}: alu_out = alu_a ^ alu_b;
                {OP_OP_IMM, 3'b110, 7'b???????}: alu_out = alu_a | alu_b;
                {OP_OP_IMM, 3'b111, 7'b???????}: alu_out = alu_a & alu_b;
                {OP_OP_IMM, 3'b001, 7'b0000000}: alu_out = alu_a << shamt;
                {OP_OP_IMM, 3'b101, 7'b0000000}: alu_out = alu_a >> shamt;
                {OP_OP_IMM, 3'b101, 7'b0100000}: alu_out = $signed(alu_a) >>> shamt;
                {OP_OP,     3'b000, 7'b0000000}: alu_out = alu_a + alu_b;
                {OP_OP,     3'b000, 7'b0100000}: alu_out = alu_a - alu_b;
                {OP_OP,     3'b001, 7'b0000000}: alu_out = alu_a << shamt;
                {OP_OP,     3'b010, 7'b0000000}: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
                {OP_OP,     3'b011, 7'b0000000}: alu_out = {31'b0, alu_a < alu_b};
                {OP_OP,     3'b100, 7'b0000000}: alu_out = alu_a ^ alu_b;
                {OP_OP,     3'b101, 7'b0000000}: alu_out = alu_a >> shamt;
                {OP_OP,     3'b101, 7'b0100000}: alu_out = $signed(alu_a) >>> shamt;
                {OP_OP,     3'b110, 7'b0000000}: alu_out = alu_a | alu_b;
                {OP_OP,     3'b111, 7'b0000000}: alu_out = alu_a & alu_b;
                {OP_OP,     3'b000, 7'b0000001}: alu_out = mul_full[`XLEN-1:0]; // MUL
                {OP_OP,     3'b001, 7'b0000001}: alu_out = mul_full[2*`XLEN-1:`XLEN]; // MULH
                {OP_OP,     3'b100, 7'b0000001}: begin // DIV
                    if (alu_b == '0)
                        alu_out = '1;
                    else if (div_ovf)
                        alu_out = 32'h8000_0000;
                    else
                        alu_out = $signed(alu_a) / $signed(alu_b);
                end
                {OP_OP,     3'b101, 7'b0000001}: alu_out = (alu_b == '0) ? '1 : alu_a / alu_b;
                {OP_OP,     3'b110, 7'b0000001}: begin // REM
                    if (alu_b == '0)
                        alu_out = alu_a;
                    else if (div_ovf)
                        alu_out = '0;
                    else
                        alu_out = $signed(alu_a) % $signed(alu_b);
                end
                {OP_OP,     3'b111, 7'b0000001}: alu_out = (alu_b == '0) ? alu_a : alu_a % alu_b;
                {OP_LUI,    3'b???, 7'b???????}: alu_out = alu_a + alu_b; // alu_a is zero
                {OP_AUIPC,  3'b???, 7'b???????}: alu_out = alu_a + alu_b;
                {OP_STORE,  3'b???, 7'b???????}: alu_out = alu_a + alu_b; // Store address
                default:                         alu_out = '0;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{mem_data[7]}}, mem_data[7:0]};
            3'b001:  load_data = {{16{mem_data[15]}}, mem_data[15:0]};
            3'b010:  load_data = mem_data;
            3'b100:  load_data = {24'b0, mem_data[7:0]};
            3'b101:  load_data = {16'b0, mem_data[15:0]};
            default: load_data = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    assign pc_plus4    = pc + 32'd4;
    assign pc_imm      = pc + imm; // JAL and branch target
    assign jalr_target = (rs1_data + imm) & ~32'd1;

    mux_key_default #(3, 7, `XLEN) result_select (
        .out        (selected),
        .key        (opcode),
        .default_out(alu_out),
        .lut        ({OP_JAL, pc_plus4, OP_JALR, pc_plus4, OP_LOAD, load_data})
    );

    mux_key_default #(3, 7, `XLEN) next_pc_select (
        .out        (next_pc),
        .key        (opcode),
        .default_out(pc_plus4),
        .lut        ({OP_JAL, pc_imm,
                      OP_JALR, jalr_target,
                      OP_BRANCH, branch_taken ? pc_imm : pc_plus4})
    );

    assign result           = inst_invalid ? '0 : selected;
    assign rd_addr_out      = rd_addr;
    assign reg_write_en_out = reg_write_en && !inst_invalid;

endmodule

//--- design/idu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module idu (
    input  logic [`XLEN-1:0] inst,
    output rv_pkg::opcode_e  opcode,
    output logic [2:0]       funct3,
    output logic [6:0]       funct7,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    output logic [4:0]       rd_addr,
    output logic [`XLEN-1:0] imm,
    output logic             reg_write_en,
    output logic             mem_write,
    output logic             inst_invalid,
    output logic             ebreak
);
    import rv_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             op_legal;
    logic             op_imm_legal;

    assign opcode   = opcode_e'(inst[6:0]);
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign funct7   = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // SUB/SRA only on funct3 000/101, MULHSU and MULHU not supported
    assign op_legal = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) ||
                      (funct7 == 7'b0000001 && funct3 != 3'b010 && funct3 != 3'b011);

    assign op_imm_legal = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                          (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                          1'b1;

    assign ebreak = (inst == 32'h0010_0073);

    always_comb begin
        imm          = '0;
        reg_write_en = 1'b0;
        mem_write    = 1'b0;
        inst_invalid = 1'b0;
        case (opcode)
            OP_LOAD: begin
                imm          = imm_i;
                reg_write_en = 1'b1;
            end
            OP_STORE: begin
                imm       = imm_s;
                mem_write = 1'b1;
            end
            OP_OP_IMM: begin
                imm          = imm_i;
                reg_write_en = 1'b1;
                inst_invalid = !op_imm_legal;
            end
            OP_OP: begin
                reg_write_en = 1'b1;
                inst_invalid = !op_legal;
            end
            OP_LUI, OP_AUIPC: begin
                imm          = imm_u;
                reg_write_en = 1'b1;
            end
            OP_JAL: begin
                imm          = imm_j;
                reg_write_en = 1'b1;
            end
            OP_JALR: begin
                imm          = imm_i;
                reg_write_en = 1'b1;
            end
            OP_BRANCH: imm = imm_b;
            OP_SYSTEM: imm = imm_i;
            default:   inst_invalid = 1'b1;
        endcase
    end

endmodule

//--- design/ifu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module ifu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] next_pc,
    input  logic             ebreak,
    input  logic             inst_invalid,
    output logic [`XLEN-1:0] pc,
    output logic             halted
);
    import rv_pkg::*;

    run_state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RUNNING;
            pc    <= `RESET_PC;
        end else if (state == RUNNING) begin
            pc <= next_pc;
            if (ebreak || inst_invalid) begin
                state <= HALTED; // Sticky until reset
            end
        end
    end

    assign halted = (state == HALTED);

endmodule

//--- design/mux_key_default.sv
`timescale 1ns/1ps

module mux_key_default #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                 out,
    input  logic [KEY_LEN-1:0]                  key,
    input  logic [DATA_LEN-1:0]                 default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    logic hit;

    // Pair listed first sits in the top bits and wins on duplicate keys
    always_comb begin
        out = default_out;
        hit = 1'b0;
        for (int i = NR_KEY - 1; i >= 0; i--) begin
            if (!hit && lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
                hit = 1'b1;
            end
        end
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       rs1_addr,
    input  logic [4:0]       rs2_addr,
    input  logic [4:0]       rd_addr,
    input  logic             write_en,
    input  logic [`XLEN-1:0] write_data,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NR_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= write_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr]; // x0 hardwired
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] mem_rdata,
    output logic [`XLEN-1:0] inst_addr,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    output logic             mem_we,
    output logic             commit_en,
    output logic [4:0]       commit_rd,
    output logic [`XLEN-1:0] commit_data,
    output logic             halted
);
    import rv_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       rd_addr;
    logic [4:0]       rd_addr_out;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] result;
    logic             reg_write_en;
    logic             reg_write_en_out;
    logic             mem_write;
    logic             inst_invalid;
    logic             ebreak;
    logic             rf_we;

    ifu u_ifu (
        .clk         (clk),
        .rst_n       (rst_n),
        .next_pc     (next_pc),
        .ebreak      (ebreak),
        .inst_invalid(inst_invalid),
        .pc          (pc),
        .halted      (halted)
    );

    idu u_idu (
        .inst        (inst),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .imm         (imm),
        .reg_write_en(reg_write_en),
        .mem_write   (mem_write),
        .inst_invalid(inst_invalid),
        .ebreak      (ebreak)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (rd_addr_out),
        .write_en  (rf_we),
        .write_data(result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    exu u_exu (
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .imm             (imm),
        .reg_write_en    (reg_write_en),
        .rd_addr         (rd_addr),
        .pc              (pc),
        .opcode          (opcode),
        .funct3          (funct3),
        .funct7          (funct7),
        .mem_data        (mem_rdata),
        .inst_invalid    (inst_invalid),
        .result          (result),
        .rd_addr_out     (rd_addr_out),
        .reg_write_en_out(reg_write_en_out),
        .next_pc         (next_pc)
    );

    assign rf_we = reg_write_en_out && !halted; // No writeback once halted

    assign inst_addr   = pc;
    assign mem_addr    = result;
    assign mem_wdata   = rs2_data;
    assign mem_we      = mem_write && !inst_invalid && !halted;
    assign commit_en   = rf_we;
    assign commit_rd   = rd_addr_out;
    assign commit_data = result;

endmodule

//--- design/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h8000_0000

// Integer register count, x0 included
`define NR_REGS 32

`endif

//--- design/rv_pkg.sv
package rv_pkg;

    // RV32 major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic {
        RUNNING = 1'b0,
        HALTED  = 1'b1
    } run_state_e;

endpackage

//--- flist.f
+incdir+design
design/rv_pkg.sv
design/mux_key_default.sv
design/ifu.sv
design/idu.sv
design/regfile.sv
design/exu.sv
design/rv_core.sv
tests/rv_core_tb.sv

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_tb;

    localparam int          CLK_PERIOD  = 4;
    localparam int          NR_STEPS    = 51;
    localparam int          NR_COLS     = 8;
    localparam logic [31:0] EBREAK_INST = 32'h0010_0073;
    localparam logic [6:0]  LOAD_OPCODE = 7'b0000011;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] mem_rdata;
    logic [31:0] inst_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        commit_en;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        halted;

    logic [31:0] test_mem [0:NR_STEPS*NR_COLS-1];
    int          check_count;
    int          error_count;
    logic        halt_expected; // Set once an EBREAK has been executed

    rv_core u_rv_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .mem_rdata  (mem_rdata),
        .inst_addr  (inst_addr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .commit_en  (commit_en),
        .commit_rd  (commit_rd),
        .commit_data(commit_data),
        .halted     (halted)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Fail %s: expected %h, got %h at %0t ns", name, exp, got, $time);
        end
    endtask

    // Load data only on load steps and noise otherwise
    task automatic drive_step(input int row);
        int base;
        base = row * NR_COLS;
        inst = test_mem[base];
        if (test_mem[base][6:0] == LOAD_OPCODE) begin
            mem_rdata = test_mem[base+1];
        end else begin
            mem_rdata = $urandom;
        end
    endtask

    task automatic compare_step(input int row);
        int base;
        base = row * NR_COLS;
        check_value("inst_addr", inst_addr, test_mem[base+2]);
        check_value("commit_en", commit_en, test_mem[base+3]);
        if (test_mem[base+3][0]) begin
            check_value("commit_rd", commit_rd, test_mem[base+4]);
            check_value("commit_data", commit_data, test_mem[base+5]);
        end
        check_value("mem_we", mem_we, test_mem[base+6]);
        if (test_mem[base+6][0]) begin
            check_value("mem_addr", mem_addr, test_mem[base+7]);
            check_value("mem_wdata", mem_wdata, test_mem[base+5]); // wdata shares the column
        end
        check_value("halted", halted, halt_expected);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        inst          = '0;
        mem_rdata     = $urandom(32'h1686);
        check_count   = 0;
        error_count   = 0;
        halt_expected = 1'b0;
        $readmemh("tests/rv_core_testdata.txt", test_mem);
        assert (!$isunknown(test_mem[NR_STEPS*NR_COLS-1])) else begin
            error_count++;
            $display("Test data file is missing or holds fewer than %0d steps", NR_STEPS);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value("inst_addr", inst_addr, `RESET_PC);
        check_value("commit_en", commit_en, 1'b0);
        check_value("halted", halted, 1'b0);
        rst_n = 1'b1;

        for (int i = 0; i < NR_STEPS; i++) begin
            drive_step(i);
            #(CLK_PERIOD/4); // Sample 1 ns before the rising edge
            compare_step(i);
            if (inst == EBREAK_INST) begin
                halt_expected = 1'b1;
            end
            @(negedge clk);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NR_STEPS + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns",
                 (NR_STEPS + 20) * CLK_PERIOD);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- tests/rv_core_testdata.txt
// Columns: inst mem_rdata inst_addr commit_en commit_rd commit_data mem_we mem_addr
// mem_rdata is used on loads only; on store rows commit_data holds the expected mem_wdata
123450B7 00000000 80000000 1 01 12345000 0 00000000 // lui   x1, 0x12345
67808093 00000000 80000004 1 01 12345678 0 00000000 // addi  x1, x1, 0x678
00001117 00000000 80000008 1 02 80001008 0 00000000 // auipc x2, 0x1
FFF00193 00000000 8000000C 1 03 FFFFFFFF 0 00000000 // addi  x3, x0, -1
00500013 00000000 80000010 1 00 00000005 0 00000000 // addi  x0, x0, 5
00100233 00000000 80000014 1 04 12345678 0 00000000 // add   x4, x0, x1
401002B3 00000000 80000018 1 05 EDCBA988 0 00000000 // sub   x5, x0, x1
0011A333 00000000 8000001C 1 06 00000001 0 00000000 // slt   x6, x3, x1
0011B3B3 00000000 80000020 1 07 00000000 0 00000000 // sltu  x7, x3, x1
4042D413 00000000 80000024 1 08 FEDCBA98 0 00000000 // srai  x8, x5, 4
0042D493 00000000 80000028 1 09 0EDCBA98 0 00000000 // srli  x9, x5, 4
00809513 00000000 8000002C 1 0A 34567800 0 00000000 // slli  x10, x1, 8
0030C5B3 00000000 80000030 1 0B EDCBA987 0 00000000 // xor   x11, x1, x3
00700693 00000000 80000034 1 0D 00000007 0 00000000 // addi  x13, x0, 7
FFD00713 00000000 80000038 1 0E FFFFFFFD 0 00000000 // addi  x14, x0, -3
02E687B3 00000000 8000003C 1 0F FFFFFFEB 0 00000000 // mul   x15, x13, x14
02109833 00000000 80000040 1 10 014B66DC 0 00000000 // mulh  x16, x1, x1
02E6C8B3 00000000 80000044 1 11 FFFFFFFE 0 00000000 // div   x17, x13, x14
02D76933 00000000 80000048 1 12 FFFFFFFD 0 00000000 // rem   x18, x14, x13
02D1D9B3 00000000 8000004C 1 13 24924924 0 00000000 // divu  x19, x3, x13
02D1FA33 00000000 80000050 1 14 00000003 0 00000000 // remu  x20, x3, x13
0206CAB3 00000000 80000054 1 15 FFFFFFFF 0 00000000 // div   x21, x13, x0
0206FB33 00000000 80000058 1 16 00000007 0 00000000 // remu  x22, x13, x0
80000BB7 00000000 8000005C 1 17 80000000 0 00000000 // lui   x23, 0x80000
023BCC33 00000000 80000060 1 18 80000000 0 00000000 // div   x24, x23, x3
023BECB3 00000000 80000064 1 19 00000000 0 00000000 // rem   x25, x23, x3
00010D03 123480F0 80000068 1 1A FFFFFFF0 0 00000000 // lb    x26, 0(x2)
00211D83 123480F0 8000006C 1 1B FFFF80F0 0 00000000 // lh    x27, 2(x2)
00412E03 123480F0 80000070 1 1C 123480F0 0 00000000 // lw    x28, 4(x2)
00014E83 123480F0 80000074 1 1D 000000F0 0 00000000 // lbu   x29, 0(x2)
00015F03 123480F0 80000078 1 1E 000080F0 0 00000000 // lhu   x30, 0(x2)
00112423 00000000 8000007C 0 00 12345678 1 80001010 // sw    x1, 8(x2)
FE310E23 00000000 80000080 0 00 FFFFFFFF 1 80001004 // sb    x3, -4(x2)
00D68463 00000000 80000084 0 00 00000000 0 00000000 // beq   x13, x13 taken
00E68463 00000000 8000008C 0 00 00000000 0 00000000 // beq   x13, x14
00E69463 00000000 80000090 0 00 00000000 0 00000000 // bne   x13, x14 taken
00D69463 00000000 80000098 0 00 00000000 0 00000000 // bne   x13, x13
00D74463 00000000 8000009C 0 00 00000000 0 00000000 // blt   x14, x13 taken
00E6C463 00000000 800000A4 0 00 00000000 0 00000000 // blt   x13, x14
00E6D463 00000000 800000A8 0 00 00000000 0 00000000 // bge   x13, x14 taken
00D75463 00000000 800000B0 0 00 00000000 0 00000000 // bge   x14, x13
00E6E463 00000000 800000B4 0 00 00000000 0 00000000 // bltu  x13, x14 taken
00D76463 00000000 800000BC 0 00 00000000 0 00000000 // bltu  x14, x13
00D77463 00000000 800000C0 0 00 00000000 0 00000000 // bgeu  x14, x13 taken
00E6F463 00000000 800000C8 0 00 00000000 0 00000000 // bgeu  x13, x14
01000FEF 00000000 800000CC 1 1F 800000D0 0 00000000 // jal   x31, +16
021F82E7 00000000 800000DC 1 05 800000E0 0 00000000 // jalr  x5, 0x21(x31)
00028333 00000000 800000F0 1 06 800000E0 0 00000000 // add   x6, x5, x0
00100073 00000000 800000F4 0 00 00000000 0 00000000 // ebreak
00100393 00000000 800000F8 0 00 00000000 0 00000000 // addi  x7, x0, 1 while halted
00112423 00000000 800000F8 0 00 00000000 0 00000000 // sw    x1, 8(x2) while halted
